// File: goertzel_coef.mem
// one q2.14 word per line, 2*cos(2*pi*k/64) for k = 0 to 63
// k = 0 held at 7fff, the largest positive q2.14 value
7FFF
7F62
7D8A
7A7D
7642
70E3
6A6E
62F2
5A82
5134
471D
3C57
30FC
2528
18F9
0C8C
0000
F374
E707
DAD8
CF04
C3A9
B8E3
AECC
A57E
9D0E
9592
8F1D
89BE
8583
8276
809E
8000
809E
8276
8583
89BE
8F1D
9592
9D0E
A57E
AECC
B8E3
C3A9
CF04
DAD8
E707
F374
0000
0C8C
18F9
2528
30FC
3C57
471D
5134
5A82
62F2
6A6E
70E3
7642
7A7D
7D8A
7F62

// File: project.f
+incdir+dv
verilog/trig_pkg.sv
verilog/frame_sequencer.sv
verilog/goertzel_bin.sv
verilog/trigger_detect.sv
verilog/trigger_fft.sv
dv/tb_trigger_fft.sv

// File: run_sim.sh
#!/bin/sh
# build and run the trigger testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_trigger_fft \
  -f project.f -o tb_trigger_fft
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_trigger_fft > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: dv/tb_helpers.svh
// trigger testbench helpers
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

localparam real two_pi = 6.283185307179586;

// galois lfsr, one step per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  if (state[0]) begin
    return (state >> 1) ^ 32'h80200003;  // taps 32 22 2 1
  end
  return state >> 1;
endfunction

// offset-binary tone sample plus noise, clamped to the input range
function automatic int tone_sample(input int bin, input int n, input int amp, input int noise);
  real phase;
  int  value;
  phase = two_pi * bin * n / n_points;
  value = sample_bias + int'(amp * $cos(phase)) + noise;
  if (value < 0) begin
    value = 0;
  end
  if (value > (1 << sample_w) - 1) begin
    value = (1 << sample_w) - 1;
  end
  return value;
endfunction

// plain dft of one bin, bias removed, |X|^2
function automatic real ref_bin_power(input int samples [n_points], input int bin);
  real re;
  real im;
  real x;
  real phase;
  int  n;
  re = 0.0;
  im = 0.0;
  for (n = 0; n < n_points; n++) begin
    x     = samples[n] - sample_bias;
    phase = two_pi * bin * n / n_points;
    re    = re + x * $cos(phase);
    im    = im - x * $sin(phase);
  end
  return re * re + im * im;
endfunction

`endif

// File: dv/tb_trigger_fft.sv
// band trigger testbench
`timescale 1ns/1ps

module tb_trigger_fft
  import trig_pkg::*;
();

  localparam int tone_bin = 5;  // tone always sits on bin 5

  logic                clk;
  logic                reset_b;
  logic                data_ready;
  logic [sample_w-1:0] input_data;
  logic [1:0]          offset;
  logic [bin_w-1:0]    frequency;
  logic [metric_w-1:0] threshold;
  logic                send_frame;
  logic                fft_data_ready;
  logic                trigger;

  logic [31:0]      lfsr_state;
  logic [bin_w-1:0] strobe_cnt;    // own count of strobes in frame
  logic             frame_expect;  // reference decision, frame being sent
  logic             first_q;       // expected send_frame
  logic [4:0]       last_pipe;     // 64th strobe walking to the result slot
  logic [4:0]       trig_pipe;     // same, gated by the decision
  int               frame_samples [n_points];

  `include "tb_helpers.svh"

  trigger_fft uut (
    .clk            (clk),
    .reset_b        (reset_b),
    .data_ready     (data_ready),
    .input_data     (input_data),
    .offset         (offset),
    .frequency      (frequency),
    .threshold      (threshold),
    .send_frame     (send_frame),
    .fft_data_ready (fft_data_ready),
    .trigger        (trigger)
  );

  always #5 clk = ~clk;

  // expected outputs from the strobe count alone
  always @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      strobe_cnt <= '0;
      first_q    <= 1'b0;
      last_pipe  <= '0;
      trig_pipe  <= '0;
    end else begin
      first_q   <= data_ready && (strobe_cnt == '0);
      last_pipe <= {last_pipe[3:0], data_ready && (strobe_cnt == bin_w'(n_points - 1))};
      trig_pipe <= {trig_pipe[3:0],
                    data_ready && (strobe_cnt == bin_w'(n_points - 1)) && frame_expect};
      if (data_ready) begin
        strobe_cnt <= strobe_cnt + 1'b1;
      end
    end
  end

  task automatic report_failure();
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  frame_start_check: assert property (
    @(posedge clk) disable iff (!reset_b) send_frame == first_q
  ) else begin
    $display("FAILED send_frame: got %h expected %h", $sampled(send_frame), $sampled(first_q));
    report_failure();
  end

  ready_timing_check: assert property (
    @(posedge clk) disable iff (!reset_b) fft_data_ready == last_pipe[4]
  ) else begin
    $display("FAILED fft_data_ready: got %h expected %h",
             $sampled(fft_data_ready), $sampled(last_pipe[4]));
    report_failure();
  end

  trigger_value_check: assert property (
    @(posedge clk) disable iff (!reset_b) trigger == trig_pipe[4]
  ) else begin
    $display("FAILED trigger: got %h expected %h", $sampled(trigger), $sampled(trig_pipe[4]));
    report_failure();
  end

  trigger_ready_check: assert property (
    @(posedge clk) disable iff (!reset_b) trigger |-> fft_data_ready
  ) else begin
    $display("trigger went high without fft_data_ready");
    report_failure();
  end

  task automatic draw_bits(input int count, output int value);
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  // power shifted by 10 plus offset, saturated to the metric range
  function automatic longint scaled_metric(input real pwr, input int off);
    longint whole;
    longint metric;
    whole = longint'(pwr);
    if (whole > (longint'(1) << power_w) - 1) begin
      whole = (longint'(1) << power_w) - 1;
    end
    metric = whole >> (metric_shift + off);
    if (metric > (1 << metric_w) - 1) begin
      metric = (1 << metric_w) - 1;
    end
    return metric;
  endfunction

  task automatic send_tone_frame(input int amp, input bit dense);
    int n;
    int bits;
    bit decision;
    for (n = 0; n < n_points; n++) begin
      draw_bits(3, bits);
      frame_samples[n] = tone_sample(tone_bin, n, amp, bits % 7 - 3);  // noise -3..3
    end
    decision = scaled_metric(ref_bin_power(frame_samples, int'(frequency)), int'(offset))
               > longint'(threshold);
    for (n = 0; n < n_points; n++) begin
      if (!dense) begin
        draw_bits(2, bits);
        repeat (bits) begin
          @(posedge clk);
          data_ready <= 1'b0;
        end
      end
      @(posedge clk);
      data_ready <= 1'b1;
      input_data <= sample_w'(frame_samples[n]);
      if (n == 0) begin
        frame_expect <= decision;
      end
    end
  endtask

  // last frame result, 5 cycles after its final strobe
  task automatic wait_result();
    int cycles;
    for (cycles = 0; cycles < 20; cycles++) begin
      @(negedge clk);
      if (fft_data_ready) begin
        return;
      end
    end
    $display("timeout waiting for fft_data_ready");
    report_failure();
  endtask

  task automatic run_case(input int bin_sel, input int off, input int thr, input int amp,
                          input int frames, input bit dense);
    int i;
    @(posedge clk);
    frequency <= bin_w'(bin_sel);
    offset    <= 2'(off);
    threshold <= metric_w'(thr);
    @(posedge clk);
    for (i = 0; i < frames; i++) begin
      send_tone_frame(amp, dense);  // back to back, two frames in flight
    end
    @(posedge clk);
    data_ready <= 1'b0;
    wait_result();
  endtask

  initial begin
    clk          = 1'b0;
    lfsr_state   = 32'ha25776ba;
    reset_b      <= 1'b0;
    data_ready   <= 1'b0;
    input_data   <= '0;
    offset       <= '0;
    frequency    <= '0;
    threshold    <= '0;
    frame_expect <= 1'b0;
    repeat (16) @(posedge clk);
    reset_b <= 1'b1;
    run_case(5, 0, 20000, 200, 3, 1'b0);    // in band, random gaps
    run_case(5, 0, 20000, 200, 2, 1'b1);    // a strobe every cycle
    run_case(20, 0, 2000, 200, 2, 1'b0);    // out of band
    run_case(5, 3, 20000, 200, 2, 1'b0);    // metric near 5000
    run_case(5, 0, 'hffff, 200, 1, 1'b0);
    run_case(5, 0, 'hffff, 500, 1, 1'b1);   // metric saturates at ffff
    run_case(5, 0, 0, 200, 2, 1'b1);
    run_case(5, 3, 0, 200, 1, 1'b0);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: verilog/trigger_fft.sv
// band energy trigger top
`timescale 1ns/1ps

module trigger_fft
  import trig_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_b,
  input  logic                 data_ready,      // sample strobe
  input  logic [sample_w-1:0]  input_data,
  input  logic [1:0]           offset,
  input  logic [bin_w-1:0]     frequency,
  input  logic [metric_w-1:0]  threshold,
  output logic                 send_frame,
  output logic                 fft_data_ready,
  output logic                 trigger
);

  logic                     sample_valid;
  logic signed [sample_w:0] sample_data;
  logic                     sample_first;
  logic                     sample_last;
  logic                     power_valid;
  logic [power_w-1:0]       power;

  frame_sequencer u_frame_sequencer (
    .clk          (clk),
    .reset_b      (reset_b),
    .data_ready   (data_ready),
    .input_data   (input_data),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .sample_first (sample_first),
    .sample_last  (sample_last),
    .send_frame   (send_frame)
  );

  goertzel_bin u_goertzel_bin (
    .clk          (clk),
    .reset_b      (reset_b),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .sample_first (sample_first),
    .sample_last  (sample_last),
    .frequency    (frequency),
    .power_valid  (power_valid),
    .power        (power)
  );

  trigger_detect u_trigger_detect (
    .clk            (clk),
    .reset_b        (reset_b),
    .power_valid    (power_valid),
    .power          (power),
    .offset         (offset),
    .threshold      (threshold),
    .fft_data_ready (fft_data_ready),
    .trigger        (trigger)
  );

endmodule

// File: verilog/trigger_detect.sv
// power scaling and threshold compare
`timescale 1ns/1ps

module trigger_detect
  import trig_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_b,
  input  logic                 power_valid,
  input  logic [power_w-1:0]   power,
  input  logic [1:0]           offset,          // extra right shift
  input  logic [metric_w-1:0]  threshold,
  output logic                 fft_data_ready,  // once per frame
  output logic                 trigger          // band energy above threshold
);

  logic [power_w-1:0]  shifted;
  logic [metric_w-1:0] metric;

  assign shifted = power >> (metric_shift + offset);

  // saturate to metric width
  always_comb begin
    if (|shifted[power_w-1:metric_w]) begin
      metric = '1;
    end else begin
      metric = shifted[metric_w-1:0];
    end
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      fft_data_ready <= 1'b0;
      trigger        <= 1'b0;
    end else begin
      fft_data_ready <= power_valid;
      trigger        <= power_valid && (metric > threshold);  // strict compare
    end
  end

  trigger_with_ready: assert property (
    @(posedge clk) disable iff (!reset_b)
    trigger |-> fft_data_ready
  ) else $error("trigger without fft_data_ready");

endmodule

// File: verilog/goertzel_bin.sv
// goertzel single bin power
`timescale 1ns/1ps

module goertzel_bin
  import trig_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset_b,
  input  logic                      sample_valid,
  input  logic signed [sample_w:0]  sample_data,
  input  logic                      sample_first,
  input  logic                      sample_last,
  input  logic [bin_w-1:0]          frequency,    // bin to watch
  output logic                      power_valid,  // one cycle strobe per frame
  output logic [power_w-1:0]        power
);

  logic signed [coef_w-1:0]  coef_rom [n_points];  // 2cos(2*pi*k/64), q2.14
  logic [bin_w-1:0]          bin_q;                // bin held for the frame
  logic [bin_w-1:0]          coef_idx;
  logic signed [coef_w-1:0]  coef;

  logic signed [state_w-1:0] s1;
  logic signed [state_w-1:0] s2;
  logic signed [prod_w-1:0]  coef_prod;            // coef * s1, unscaled
  logic signed [prod_w-1:0]  s0_wide;
  logic signed [state_w-1:0] s0;                   // next state

  // handoff to power pipe
  logic                      fin_valid;
  logic signed [state_w-1:0] fin_s1;
  logic signed [state_w-1:0] fin_s2;
  logic signed [coef_w-1:0]  fin_coef;
  logic signed [cross_w-1:0] cross_full;

  // power stage one
  logic                      p1_valid;
  logic signed [sq_w-1:0]    p1_sq1;
  logic signed [sq_w-1:0]    p1_sq2;
  logic signed [cross_w-1:0] p1_cross;
  logic signed [cross_w:0]   diff;
  logic [power_w-1:0]        power_next;

  initial begin
    $readmemh("goertzel_coef.mem", coef_rom);
  end

  assign coef_idx = sample_first ? frequency : bin_q;  // new bin takes effect at once
  assign coef     = coef_rom[coef_idx];

  // s0 = x + coef*s1 - s2
  assign coef_prod = coef * s1;
  assign s0_wide   = sample_data + (coef_prod >>> coef_frac) - s2;
  assign s0        = s0_wide[state_w-1:0];

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      bin_q     <= '0;
      s1        <= '0;
      s2        <= '0;
      fin_valid <= 1'b0;
    end else begin
      fin_valid <= sample_valid && sample_last;
      if (sample_valid) begin
        if (sample_first) begin
          bin_q <= frequency;
        end
        if (sample_last) begin
          s1 <= '0;  // clean start for next frame
          s2 <= '0;
        end else begin
          s1 <= s0;
          s2 <= s1;
        end
      end
    end
  end

  // final states, last sample folded in
  always_ff @(posedge clk) begin
    if (sample_valid && sample_last) begin
      fin_s1   <= s0;
      fin_s2   <= s1;
      fin_coef <= coef;  // own copy, bin may change next frame
    end
  end

  assign cross_full = fin_coef * fin_s1 * fin_s2;

  always_ff @(posedge clk) begin
    if (fin_valid) begin
      p1_sq1   <= fin_s1 * fin_s1;
      p1_sq2   <= fin_s2 * fin_s2;
      p1_cross <= cross_full >>> coef_frac;
    end
  end

  // s1^2 + s2^2 - coef*s1*s2, clamped to power range
  assign diff = p1_sq1 + p1_sq2 - p1_cross;

  always_comb begin
    if (diff < 0) begin
      power_next = '0;  // rounding can dip below zero
    end else if (|diff[cross_w:power_w]) begin
      power_next = '1;
    end else begin
      power_next = diff[power_w-1:0];
    end
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      p1_valid    <= 1'b0;
      power_valid <= 1'b0;
    end else begin
      p1_valid    <= fin_valid;
      power_valid <= p1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (p1_valid) begin
      power <= power_next;
    end
  end

  // frame end to power strobe, exactly three cycles both ways
  last_to_power: assert property (
    @(posedge clk) disable iff (!reset_b)
    (sample_valid && sample_last) |-> ##3 power_valid
  ) else $error("power_valid late or missing after last sample");

  power_from_last: assert property (
    @(posedge clk) disable iff (!reset_b)
    power_valid |-> $past(sample_valid && sample_last, 3)
  ) else $error("power_valid without a last sample three cycles earlier");

endmodule

// File: verilog/frame_sequencer.sv
// sample framing and bias removal
`timescale 1ns/1ps

module frame_sequencer
  import trig_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset_b,
  input  logic                      data_ready,    // one strobe per sample
  input  logic [sample_w-1:0]       input_data,    // offset binary
  output logic                      sample_valid,  // strobe, one cycle after data_ready
  output logic signed [sample_w:0]  sample_data,   // two's complement, bias removed
  output logic                      sample_first,  // first sample of frame
  output logic                      sample_last,   // 64th sample of frame
  output logic                      send_frame     // frame start pulse
);

  logic [bin_w-1:0] sample_cnt;  // position inside current frame
  logic             at_first;
  logic             at_last;

  assign at_first = (sample_cnt == '0);
  assign at_last  = (sample_cnt == bin_w'(n_points - 1));

  // counter and flags, flags only with a strobe
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      sample_cnt   <= '0;
      sample_valid <= 1'b0;
      sample_first <= 1'b0;
      sample_last  <= 1'b0;
    end else begin
      sample_valid <= data_ready;
      sample_first <= data_ready && at_first;
      sample_last  <= data_ready && at_last;
      if (data_ready) begin
        sample_cnt <= sample_cnt + 1'b1;  // wraps at n_points
      end
    end
  end

  // payload, loaded with the strobe
  always_ff @(posedge clk) begin
    if (data_ready) begin
      sample_data <= $signed({1'b0, input_data} - (sample_w + 1)'(sample_bias));
    end
  end

  assign send_frame = sample_first;  // already qualified by the strobe

  // frame flags must ride on a valid sample
  flags_need_valid: assert property (
    @(posedge clk) disable iff (!reset_b)
    (sample_first || sample_last) |-> sample_valid
  ) else $error("frame flag without sample_valid");

endmodule

// File: verilog/trig_pkg.sv
// trigger path constants
package trig_pkg;

  // frame and sample geometry
  localparam int n_points    = 64;   // samples per frame
  localparam int bin_w       = 6;    // bin index and sample index width
  localparam int sample_w    = 10;   // raw offset-binary sample
  localparam int sample_bias = 512;  // offset-binary midpoint

  // goertzel arithmetic
  localparam int coef_w    = 16;  // signed q2.14 coefficient
  localparam int coef_frac = 14;  // fraction bits of coef
  localparam int state_w   = 24;  // s1 / s2 width, signed

  // derived product widths
  localparam int prod_w  = coef_w + state_w;      // coef * s1
  localparam int sq_w    = 2 * state_w;           // s1 * s1
  localparam int cross_w = coef_w + 2 * state_w;  // coef * s1 * s2

  // power and metric
  localparam int power_w      = 40;  // unsigned bin power
  localparam int metric_shift = 10;  // fixed shift before offset
  localparam int metric_w     = 16;  // scaled metric and threshold

endpackage
